/* rtl/hex_display_consts.svh */
`ifndef HEX_DISPLAY_CONSTS_SVH
`define HEX_DISPLAY_CONSTS_SVH

// Digits on the board, HEX0 through HEX5
`define HEX_NUM_DIGITS 6

// Register bus widths
`define HEX_ADDR_W 3
`define HEX_DATA_W 8

// Fixed register addresses above the digit block
`define HEX_CTRL_ADDR 3'd6
`define HEX_ID_ADDR 3'd7

// Clock cycles per blink phase, kept short for simulation
`define HEX_BLINK_DIV 16

// Constant returned at the ID address
`define HEX_PERIPH_ID 8'hA5

`endif

/* rtl/hex_display_pkg.sv */
`default_nettype none

`include "hex_display_consts.svh"

package hex_display_pkg;

  // Processor side request, sampled every cycle
  typedef struct packed {
    logic                     write;
    logic                     read;
    logic [`HEX_ADDR_W-1:0]   address;
    logic [`HEX_DATA_W-1:0]   writedata;
  } bus_req_t;

  // One digit register, laid out as in writedata bits 5..0
  typedef struct packed {
    logic       blink;
    logic       blank;
    logic [3:0] value;
  } digit_cfg_t;

  // Global control register, bit 0 is display_en
  typedef struct packed {
    logic blink_en;
    logic display_en;
  } ctrl_t;

  // Register classes on the bus
  typedef enum logic [1:0] {
    OP_NONE,
    OP_DIGIT,
    OP_CTRL,
    OP_ID
  } reg_op_e;

  // Address classification, shared by decoder and readback
  function automatic reg_op_e addr_to_op(input logic strobe,
                                         input logic [`HEX_ADDR_W-1:0] addr);
    if (!strobe) return OP_NONE;
    if (addr < `HEX_NUM_DIGITS) return OP_DIGIT;
    if (addr == `HEX_CTRL_ADDR) return OP_CTRL;
    if (addr == `HEX_ID_ADDR) return OP_ID;
    return OP_NONE;
  endfunction

endpackage

`default_nettype wire

/* rtl/hex_reg_decoder.sv */
`timescale 1ns/10ps
`default_nettype none

`include "hex_display_consts.svh"

module hex_reg_decoder (
  input  logic                              clk,
  input  logic                              rst,
  input  hex_display_pkg::bus_req_t         req,
  output logic [`HEX_NUM_DIGITS-1:0]        digit_load,
  output hex_display_pkg::digit_cfg_t       digit_wdata,
  output hex_display_pkg::ctrl_t            ctrl
);

  import hex_display_pkg::*;

  // ========================================
  // Write classification
  // ========================================

  reg_op_e wr_op;

  // Reads never touch state here
  assign wr_op = addr_to_op(req.write, req.address);

  // Digit payload, bits 7..6 dropped
  assign digit_wdata = digit_cfg_t'(req.writedata[5:0]);

  // One load pulse for the addressed digit
  // Channel samples it on the same edge as the write
  always_comb begin
    digit_load = '0;
    for (int i = 0; i < `HEX_NUM_DIGITS; i++) begin
      if (wr_op == OP_DIGIT && req.address == `HEX_ADDR_W'(i)) begin
        digit_load[i] = 1'b1;
      end
    end
  end

  // ========================================
  // Control register
  // ========================================

  // Display and blink both off after reset
  always_ff @(posedge clk) begin
    if (rst) begin
      ctrl <= '0;
    end else if (wr_op == OP_CTRL) begin
      ctrl <= ctrl_t'(req.writedata[1:0]);
    end
  end

  // Writes to the ID address fall through as no-ops

  // ========================================
  // Checks
  // ========================================

  // Bus master never issues both strobes at once
  a_no_rd_wr_overlap : assert property (
    @(posedge clk) disable iff (rst)
    !(req.write && req.read)
  ) else $error("write and read strobes high together");

endmodule

`default_nettype wire

/* rtl/hex_digit_channel.sv */
`timescale 1ns/10ps
`default_nettype none

module hex_digit_channel (
  input  logic                          clk,
  input  logic                          rst,
  input  logic                          load,
  input  hex_display_pkg::digit_cfg_t   wdata,
  input  hex_display_pkg::ctrl_t        ctrl,
  input  logic                          blink_phase,
  output hex_display_pkg::digit_cfg_t   cfg,
  output logic [6:0]                    seg
);

  import hex_display_pkg::*;

  // Active low, bit 0 is segment a, bit 6 is segment g
  function automatic logic [6:0] hex_font(input logic [3:0] v);
    case (v)
      4'h0:    return 7'b1000000;
      4'h1:    return 7'b1111001;
      4'h2:    return 7'b0100100;
      4'h3:    return 7'b0110000;
      4'h4:    return 7'b0011001;
      4'h5:    return 7'b0010010;
      4'h6:    return 7'b0000010;
      4'h7:    return 7'b1111000;
      4'h8:    return 7'b0000000;
      4'h9:    return 7'b0010000;
      4'hA:    return 7'b0001000;
      4'hB:    return 7'b0000011;
      4'hC:    return 7'b1000110;
      4'hD:    return 7'b0100001;
      4'hE:    return 7'b0000110;
      default: return 7'b0001110;
    endcase
  endfunction

  // ========================================
  // Digit register
  // ========================================

  // Updated on the write edge
  always_ff @(posedge clk) begin
    if (rst) begin
      cfg <= '0;
    end else if (load) begin
      cfg <= wdata;
    end
  end

  // ========================================
  // Segment output
  // ========================================

  logic dark;

  // Blinking digit goes dark in phase zero
  assign dark = !ctrl.display_en
             || cfg.blank
             || (cfg.blink && ctrl.blink_en && !blink_phase);

  // One edge after the digit register
  always_ff @(posedge clk) begin
    if (rst) begin
      seg <= '1;
    end else if (dark) begin
      seg <= '1;
    end else begin
      seg <= hex_font(cfg.value);
    end
  end

  // ========================================
  // Checks
  // ========================================

  // Blank always wins on the next edge
  a_blank_dark : assert property (
    @(posedge clk) disable iff (rst)
    cfg.blank |=> (seg == 7'h7f)
  ) else $error("blanked digit not dark");

endmodule

`default_nettype wire

/* rtl/blink_timer.sv */
`timescale 1ns/10ps
`default_nettype none

`include "hex_display_consts.svh"

module blink_timer (
  input  logic clk,
  input  logic rst,
  output logic blink_phase
);

  localparam int CNT_W = $clog2(`HEX_BLINK_DIV);
  localparam logic [CNT_W-1:0] CNT_LAST = CNT_W'(`HEX_BLINK_DIV - 1);

  logic [CNT_W-1:0] cnt;

  // ========================================
  // Divider
  // ========================================

  // Phase flips on every wrap of the counter
  always_ff @(posedge clk) begin
    if (rst) begin
      cnt         <= '0;
      blink_phase <= 1'b0;
    end else if (cnt == CNT_LAST) begin
      cnt         <= '0;
      blink_phase <= ~blink_phase;
    end else begin
      cnt <= cnt + 1'b1;
    end
  end

  // Phase holds for a full divider period
  a_phase_stable : assert property (
    @(posedge clk) disable iff (rst)
    $changed(blink_phase) |=> $stable(blink_phase)
  ) else $error("blink phase toggled twice in a row");

endmodule

`default_nettype wire

/* rtl/hex_readback.sv */
`timescale 1ns/10ps
`default_nettype none

`include "hex_display_consts.svh"

module hex_readback (
  input  logic                                              clk,
  input  logic                                              rst,
  input  hex_display_pkg::bus_req_t                         req,
  input  hex_display_pkg::digit_cfg_t [`HEX_NUM_DIGITS-1:0] cfg,
  input  hex_display_pkg::ctrl_t                            ctrl,
  output logic [`HEX_DATA_W-1:0]                            readdata,
  output logic                                              rdvalid
);

  import hex_display_pkg::*;

  reg_op_e                rd_op;
  logic [`HEX_DATA_W-1:0] rd_mux;

  // ========================================
  // Read select
  // ========================================

  assign rd_op = addr_to_op(req.read, req.address);

  // Unused upper bits read as zero
  always_comb begin
    case (rd_op)
      OP_DIGIT: rd_mux = `HEX_DATA_W'(cfg[req.address]);
      OP_CTRL:  rd_mux = `HEX_DATA_W'(ctrl);
      OP_ID:    rd_mux = `HEX_PERIPH_ID;
      default:  rd_mux = '0;
    endcase
  end

  // ========================================
  // Output register
  // ========================================

  // Data held until the next read, valid is a single pulse
  always_ff @(posedge clk) begin
    if (rst) begin
      readdata <= '0;
      rdvalid  <= 1'b0;
    end else begin
      rdvalid <= req.read;
      if (req.read) begin
        readdata <= rd_mux;
      end
    end
  end

  // Every valid pulse traces back to a read strobe
  a_rdvalid_after_read : assert property (
    @(posedge clk) disable iff (rst)
    rdvalid |-> $past(req.read)
  ) else $error("rdvalid without a preceding read");

endmodule

`default_nettype wire

/* rtl/hex_display_periph.sv */
`timescale 1ns/10ps
`default_nettype none

`include "hex_display_consts.svh"

module hex_display_periph (
  input  logic                                  clk,
  input  logic                                  rst,
  input  hex_display_pkg::bus_req_t             req,
  output logic [`HEX_DATA_W-1:0]                readdata,
  output logic                                  rdvalid,
  output logic [`HEX_NUM_DIGITS-1:0][6:0]       hex
);

  import hex_display_pkg::*;

  // ========================================
  // Internal nets
  // ========================================

  // Decoder to channels
  logic [`HEX_NUM_DIGITS-1:0] digit_load;
  digit_cfg_t                 digit_wdata;
  ctrl_t                      ctrl;

  // Shared blink phase
  logic blink_phase;

  // Channels to readback
  digit_cfg_t [`HEX_NUM_DIGITS-1:0] chan_cfg;

  // ========================================
  // Register decode
  // ========================================

  hex_reg_decoder decoder_i (
    .clk         ( clk         ),
    .rst         ( rst         ),
    .req         ( req         ),
    .digit_load  ( digit_load  ),
    .digit_wdata ( digit_wdata ),
    .ctrl        ( ctrl        )
  );

  // ========================================
  // Blink phase
  // ========================================

  blink_timer blink_i (
    .clk         ( clk         ),
    .rst         ( rst         ),
    .blink_phase ( blink_phase )
  );

  // ========================================
  // Digit channels
  // ========================================

  // Channel i drives HEX i
  for (genvar i = 0; i < `HEX_NUM_DIGITS; i++) begin : g_digit
    hex_digit_channel channel_i (
      .clk         ( clk           ),
      .rst         ( rst           ),
      .load        ( digit_load[i] ),
      .wdata       ( digit_wdata   ),
      .ctrl        ( ctrl          ),
      .blink_phase ( blink_phase   ),
      .cfg         ( chan_cfg[i]   ),
      .seg         ( hex[i]        )
    );
  end

  // ========================================
  // Read data
  // ========================================

  hex_readback readback_i (
    .clk      ( clk      ),
    .rst      ( rst      ),
    .req      ( req      ),
    .cfg      ( chan_cfg ),
    .ctrl     ( ctrl     ),
    .readdata ( readdata ),
    .rdvalid  ( rdvalid  )
  );

endmodule

`default_nettype wire

/* sim/hex_display_tb.sv */
`timescale 1ns/10ps
`default_nettype none

`include "hex_display_consts.svh"

module hex_display_tb;

  import hex_display_pkg::*;

  localparam int CLK_PERIOD = 10;
  localparam int NUM_WR     = 40;
  localparam int WR_CYC     = 4;
  localparam int BLINK_WIN  = 2 * `HEX_BLINK_DIV;
  localparam int NUM_RD     = 10;
  localparam int RD_CYC     = 3;
  // Rough length of all tests plus slack for the watchdog
  localparam int TOTAL_CYC  = 4 + (NUM_WR + 12) * WR_CYC + 2 * (BLINK_WIN + 4)
                              + NUM_RD * RD_CYC + 10;
  localparam int MARGIN_CYC = 200;

  // Active low font with bit 0 as segment a
  localparam logic [6:0] FONT [16] = '{
    7'h40, 7'h79, 7'h24, 7'h30, 7'h19, 7'h12, 7'h02, 7'h78,
    7'h00, 7'h10, 7'h08, 7'h03, 7'h46, 7'h21, 7'h06, 7'h0e
  };

  logic                                  clk;
  logic                                  rst;
  bus_req_t                              req;
  logic [`HEX_DATA_W-1:0]                readdata;
  logic                                  rdvalid;
  logic [`HEX_NUM_DIGITS-1:0][6:0]       hex;

  int    mismatch_cnt;
  int    fail_cnt;
  string test_name;

  // ========================================
  // DUT and clock
  // ========================================

  hex_display_periph dut_i (
    .clk      ( clk      ),
    .rst      ( rst      ),
    .req      ( req      ),
    .readdata ( readdata ),
    .rdvalid  ( rdvalid  ),
    .hex      ( hex      )
  );

  initial begin
    clk = 1'b0;
    forever #(CLK_PERIOD / 2) clk = ~clk;
  end

  // ========================================
  // Reference model
  // ========================================

  digit_cfg_t                      m_cfg [`HEX_NUM_DIGITS];
  ctrl_t                           m_ctrl;
  int                              m_cnt;
  logic                            m_phase;
  logic [`HEX_NUM_DIGITS-1:0][6:0] exp_hex;
  logic [`HEX_DATA_W-1:0]          exp_rdata;
  // Write value pipeline for the latency check
  logic [3:0]                      wd_d1;
  logic [3:0]                      wd_d2;

  // Register map as seen by a read
  function automatic logic [7:0] read_expect(input logic [2:0] addr);
    if (addr < `HEX_NUM_DIGITS) return {2'b00, m_cfg[addr]};
    if (addr == 3'd6) return {6'b0, m_ctrl};
    return `HEX_PERIPH_ID;
  endfunction

  always @(posedge clk) begin
    if (rst) begin
      for (int i = 0; i < `HEX_NUM_DIGITS; i++) begin
        m_cfg[i]   <= '0;
        exp_hex[i] <= '1;
      end
      m_ctrl    <= '0;
      m_cnt     <= 0;
      m_phase   <= 1'b0;
      exp_rdata <= '0;
      wd_d1     <= '0;
      wd_d2     <= '0;
    end else begin
      // Phase flips once per divider period
      if (m_cnt == `HEX_BLINK_DIV - 1) begin
        m_cnt   <= 0;
        m_phase <= ~m_phase;
      end else begin
        m_cnt <= m_cnt + 1;
      end
      // Segments follow the register one edge later
      for (int i = 0; i < `HEX_NUM_DIGITS; i++) begin
        if (!m_ctrl.display_en || m_cfg[i].blank
            || (m_cfg[i].blink && m_ctrl.blink_en && !m_phase)) begin
          exp_hex[i] <= '1;
        end else begin
          exp_hex[i] <= FONT[m_cfg[i].value];
        end
      end
      // Writes to the ID address are dropped
      if (req.write) begin
        if (req.address < `HEX_NUM_DIGITS) begin
          m_cfg[req.address] <= digit_cfg_t'(req.writedata[5:0]);
        end else if (req.address == 3'd6) begin
          m_ctrl <= ctrl_t'(req.writedata[1:0]);
        end
      end
      if (req.read) begin
        exp_rdata <= read_expect(req.address);
      end
      wd_d1 <= req.writedata[3:0];
      wd_d2 <= wd_d1;
    end
  end

  // ========================================
  // Concurrent checks
  // ========================================

  for (genvar i = 0; i < `HEX_NUM_DIGITS; i++) begin : g_check
    localparam logic [2:0] ADDR = 3'(i);

    // Every digit tracks the model on every cycle
    a_hex_model : assert property (
      @(posedge clk) disable iff (rst)
      hex[i] == exp_hex[i]
    ) else begin
      mismatch_cnt++;
      $display("MISMATCH %s hex%0d expected %h actual %h", test_name, i,
               $sampled(exp_hex[i]), $sampled(hex[i]));
    end

    // Plain digit write shows its font two edges later
    a_write_latency : assert property (
      @(posedge clk) disable iff (rst)
      (req.write && req.address == ADDR && req.writedata[5:4] == 2'b00
       && m_ctrl.display_en) |-> ##2 (hex[i] == FONT[wd_d2])
    ) else begin
      mismatch_cnt++;
      $display("MISMATCH %s hex%0d latency expected %h actual %h", test_name, i,
               FONT[$sampled(wd_d2)], $sampled(hex[i]));
    end

    // Blank or display off means dark on the next edge
    a_dark : assert property (
      @(posedge clk) disable iff (rst)
      (m_cfg[i].blank || !m_ctrl.display_en) |=> (hex[i] == 7'h7f)
    ) else begin
      mismatch_cnt++;
      $display("MISMATCH %s hex%0d dark expected 7f actual %h", test_name, i,
               $sampled(hex[i]));
    end
  end

  // Single valid pulse one cycle after each read
  a_rdvalid_pulse : assert property (
    @(posedge clk) disable iff (rst)
    req.read |=> rdvalid
  ) else begin
    fail_cnt++;
    $display("%s: rdvalid did not follow a read strobe", test_name);
  end

  a_rdvalid_quiet : assert property (
    @(posedge clk) disable iff (rst)
    !req.read |=> !rdvalid
  ) else begin
    fail_cnt++;
    $display("%s: rdvalid high without a read one cycle earlier", test_name);
  end

  a_readdata : assert property (
    @(posedge clk) disable iff (rst)
    rdvalid |-> (readdata == exp_rdata)
  ) else begin
    mismatch_cnt++;
    $display("MISMATCH %s readdata expected %h actual %h", test_name,
             $sampled(exp_rdata), $sampled(readdata));
  end

  // ========================================
  // Stimulus tasks
  // ========================================

  // All bus tasks start and end on a falling edge
  task automatic idle(input int n);
    repeat (n) @(negedge clk);
  endtask

  task automatic bus_write(input logic [2:0] addr, input logic [7:0] data);
    req.write     = 1'b1;
    req.read      = 1'b0;
    req.address   = addr;
    req.writedata = data;
    @(negedge clk);
    req = '0;
  endtask

  task automatic bus_read(input logic [2:0] addr);
    req.read    = 1'b1;
    req.write   = 1'b0;
    req.address = addr;
    @(negedge clk);
    req = '0;
  endtask

  // Samples one digit over a full blink window
  task automatic watch_blink(input int d, input bit want_toggle);
    bit seen_dark;
    bit seen_lit;
    seen_dark = 1'b0;
    seen_lit  = 1'b0;
    repeat (BLINK_WIN) begin
      @(negedge clk);
      if (hex[d] == 7'h7f) seen_dark = 1'b1;
      else seen_lit = 1'b1;
    end
    if (want_toggle) begin
      assert (seen_dark && seen_lit) else begin
        fail_cnt++;
        $display("%s: hex%0d did not blink within the window", test_name, d);
      end
    end else begin
      assert (seen_lit && !seen_dark) else begin
        fail_cnt++;
        $display("%s: hex%0d went dark with blink disabled", test_name, d);
      end
    end
  endtask

  // ========================================
  // Watchdog
  // ========================================

  initial begin
    #(CLK_PERIOD * (TOTAL_CYC + MARGIN_CYC));
    $display("watchdog expired before the tests completed");
    $display("tests failed");
    $finish;
  end

  // ========================================
  // Test sequence
  // ========================================

  initial begin
    logic [2:0] addr;
    mismatch_cnt = 0;
    fail_cnt     = 0;
    test_name    = "reset";
    req          = '0;
    rst          = 1'b1;
    void'($urandom(32'h869f5740));
    repeat (2) @(posedge clk);
    @(negedge clk);
    rst = 1'b0;

    // Everything dark straight out of reset
    assert (hex == '1) else begin
      mismatch_cnt++;
      $display("MISMATCH %s hex expected %h actual %h", test_name, {42{1'b1}}, hex);
    end
    assert (!rdvalid) else begin
      fail_cnt++;
      $display("%s: rdvalid high after reset", test_name);
    end
    assert (readdata == '0) else begin
      mismatch_cnt++;
      $display("MISMATCH %s readdata expected %h actual %h", test_name, 8'h00, readdata);
    end

    test_name = "digit_write";
    bus_write(3'd6, 8'h01);
    idle(2);
    for (int n = 0; n < NUM_WR; n++) begin
      addr = 3'($urandom_range(0, `HEX_NUM_DIGITS - 1));
      bus_write(addr, {4'h0, 4'($urandom)});
      idle(WR_CYC - 1);
    end

    test_name = "blank";
    bus_write(3'($urandom_range(0, `HEX_NUM_DIGITS - 1)), 8'h1c);
    idle(WR_CYC);
    bus_write(3'd6, 8'h00);
    idle(WR_CYC);
    bus_write(3'd6, 8'h01);
    idle(WR_CYC);

    test_name = "blink";
    bus_write(3'd2, 8'h28);
    bus_write(3'd6, 8'h03);
    idle(2);
    watch_blink(2, 1'b1);
    bus_write(3'd6, 8'h01);
    idle(2);
    watch_blink(2, 1'b0);

    // Upper data bits and ID writes are dropped
    test_name = "readback";
    bus_write(3'd0, 8'hc7);
    bus_write(3'd7, 8'h3c);
    idle(2);
    for (int a = 0; a < 8; a++) begin
      bus_read(3'(a));
      idle(RD_CYC - 1);
    end
    bus_read(3'd0);
    idle(RD_CYC - 1);
    bus_read(3'd7);
    idle(4);

    $display("summary: %0d value mismatches, %0d other errors", mismatch_cnt, fail_cnt);
    if (mismatch_cnt == 0 && fail_cnt == 0) begin
      $display("all tests passed");
    end else begin
      $display("tests failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* list.f */
+incdir+rtl
rtl/hex_display_pkg.sv
rtl/hex_reg_decoder.sv
rtl/hex_digit_channel.sv
rtl/blink_timer.sv
rtl/hex_readback.sv
rtl/hex_display_periph.sv
sim/hex_display_tb.sv
